/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := bsc_tb
FILELIST  := project.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
RUNFLAGS  ?= +verilator+error+limit+1000
SRCS      := $(wildcard design/*.sv testbench/*.sv include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNFLAGS))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJDIR)

/* design/bsc_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bsc_bus_arbiter (
   input  wire                      clk,
   input  wire                      i_rst,
   input  wire                      i_load_en,
   input  wire bsc_pkg::mem_addr_t  i_load_addr,
   input  wire bsc_pkg::word_t      i_load_data,
   input  wire                      i_dbus_req,
   input  wire                      i_dbus_we,
   input  wire bsc_pkg::mem_addr_t  i_dbus_addr,
   input  wire bsc_pkg::word_t      i_dbus_wdata,
   input  wire                      i_ibus_req,
   input  wire bsc_pkg::mem_addr_t  i_ibus_addr,
   output logic                     o_mem_en,
   output logic                     o_mem_we,
   output bsc_pkg::mem_addr_t       o_mem_addr,
   output bsc_pkg::word_t           o_mem_wdata,
   input  wire                      i_mem_ack,
   output logic                     o_dbus_ack,
   output logic                     o_ibus_ack
);

   logic gnt_d, gnt_i, gnt_d_r, gnt_i_r, busy;

   // a core request still holds its level in the cycle of its ack
   assign busy  = gnt_d_r | gnt_i_r;
   assign gnt_d = ~i_load_en & ~busy & i_dbus_req;
   assign gnt_i = ~i_load_en & ~busy & ~i_dbus_req & i_ibus_req;

   assign o_mem_en    = i_load_en | gnt_d | gnt_i;
   assign o_mem_we    = i_load_en | (gnt_d & i_dbus_we);
   assign o_mem_addr  = i_load_en ? i_load_addr : (gnt_d ? i_dbus_addr : i_ibus_addr);
   assign o_mem_wdata = i_load_en ? i_load_data : i_dbus_wdata;

   assign o_dbus_ack = i_mem_ack & gnt_d_r;
   assign o_ibus_ack = i_mem_ack & gnt_i_r;

   always_ff @(posedge clk) begin
      gnt_d_r <= gnt_d;
      gnt_i_r <= gnt_i;
      if (i_rst) begin
         gnt_d_r <= 1'b0;
         gnt_i_r <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* design/bsc_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bsc_cfg.svh"

module bsc_datapath (
   input  wire                      clk,
   input  wire                      i_rst,
   input  wire bsc_pkg::bit_cnt_t   i_cnt,
   input  wire                      i_cnt_en,
   input  wire                      i_init,
   input  wire                      i_run,
   input  wire                      i_rs1_bit,
   input  wire                      i_rs2_bit,
   input  wire                      i_imm_bit,
   input  wire                      i_alu_sub,
   input  wire [1:0]                i_alu_bool_op,
   input  wire                      i_op_b_imm,
   input  wire                      i_rd_sel_mem,
   input  wire                      i_pc_en,
   input  wire                      i_jump_sel,
   input  wire bsc_pkg::word_t      i_dbus_rdt,
   output logic                     o_rd_bit,
   output logic                     o_cmp_eq,
   output bsc_pkg::word_t           o_pc,
   output bsc_pkg::mem_addr_t       o_mem_addr
);

   logic first;
   logic op_b, cin, add_bit, carry, bool_bit;
   logic eq_r;
   logic pc_bit, pc4_bit, c4, c4_in, tgt_bit, cj, cj_in;
   bsc_pkg::word_t pc_next, addr_buf, load_word;

   assign first = (i_cnt == 5'd0);

   // serial adder that subtracts with the inverted operand and a carry in of one
   assign op_b    = (i_op_b_imm ? i_imm_bit : i_rs2_bit) ^ i_alu_sub;
   assign cin     = first ? i_alu_sub : carry;
   assign add_bit = i_rs1_bit ^ op_b ^ cin;

   always_comb begin
      case (i_alu_bool_op)
         2'b01:   bool_bit = i_rs1_bit ^ op_b;
         2'b10:   bool_bit = i_rs1_bit | op_b;
         default: bool_bit = i_rs1_bit & op_b;
      endcase
   end

   // current pc bit plus 4 and plus immediate
   assign pc_bit  = o_pc[i_cnt];
   assign c4_in   = first ? 1'b0 : c4;
   assign pc4_bit = pc_bit ^ (i_cnt == 5'd2) ^ c4_in;
   assign cj_in   = first ? 1'b0 : cj;
   assign tgt_bit = pc_bit ^ i_imm_bit ^ cj_in;

   // jal writes the return address
   always_comb begin
      if (i_rd_sel_mem)
         o_rd_bit = load_word[0];
      else if (i_jump_sel)
         o_rd_bit = pc4_bit;
      else if (i_alu_bool_op == 2'b00)
         o_rd_bit = add_bit;
      else
         o_rd_bit = bool_bit;
   end

   // equality including the bit on the operand lines this cycle
   assign o_cmp_eq   = (first | eq_r) & ~(i_rs1_bit ^ i_rs2_bit);
   assign o_mem_addr = addr_buf[9:2];

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry <= (i_rs1_bit & op_b) | (cin & (i_rs1_bit ^ op_b));
      end
      if (i_init & i_cnt_en) begin
         eq_r     <= o_cmp_eq;
         addr_buf <= {add_bit, addr_buf[31:1]};
      end
      if (i_run & i_cnt_en) begin
         c4        <= (pc_bit & (i_cnt == 5'd2)) | (c4_in & (pc_bit ^ (i_cnt == 5'd2)));
         cj        <= (pc_bit & i_imm_bit) | (cj_in & (pc_bit ^ i_imm_bit));
         pc_next   <= {i_jump_sel ? tgt_bit : pc4_bit, pc_next[31:1]};
         load_word <= {1'b0, load_word[31:1]};
      end else if (!i_cnt_en) begin
         // memory read data stays valid until the next grant
         load_word <= i_dbus_rdt;
      end
      if (i_pc_en)
         o_pc <= pc_next;
      if (i_rst) begin
         o_pc  <= `BSC_RESET_PC;
         carry <= 1'b0;
         c4    <= 1'b0;
         cj    <= 1'b0;
         eq_r  <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* design/bsc_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module bsc_decode (
   input  wire                       clk,
   input  wire                       i_rst,
   output logic                      o_ibus_req,
   input  wire                       i_ibus_ack,
   input  wire bsc_pkg::word_t       i_ibus_rdt,
   output logic                      o_dbus_req,
   output logic                      o_dbus_we,
   input  wire                       i_dbus_ack,
   output bsc_pkg::bit_cnt_t         o_cnt,
   output logic                      o_cnt_en,
   output logic                      o_init,
   output logic                      o_run,
   output logic                      o_rf_read,
   output logic                      o_rf_we,
   output bsc_pkg::reg_addr_t        o_rs1_addr,
   output bsc_pkg::reg_addr_t        o_rs2_addr,
   output bsc_pkg::reg_addr_t        o_rd_addr,
   output logic                      o_imm_bit,
   output logic                      o_alu_sub,
   output logic [1:0]                o_alu_bool_op,
   output logic                      o_op_b_imm,
   output logic                      o_rd_sel_mem,
   output logic                      o_pc_en,
   output logic                      o_jump_sel,
   input  wire                       i_cmp_eq,
   output logic                      o_retire
);

   bsc_pkg::decode_state_t state;
   bsc_pkg::funct3_t       funct3;
   logic [4:0]             opcode;
   logic                   sub_bit;
   bsc_pkg::word_t         imm;
   logic                   taken_r;

   logic is_op, is_opimm, is_lui, is_load, is_store, is_branch, is_jal;
   logic two_stage;
   logic sign_bit;
   logic [4:0] new_op;

   // opcode bits [6:2] of the latched instruction
   assign is_opimm  = (opcode == 5'b00100);
   assign is_op     = (opcode == 5'b01100);
   assign is_lui    = (opcode == 5'b01101);
   assign is_load   = (opcode == 5'b00000);
   assign is_store  = (opcode == 5'b01000);
   assign is_branch = (opcode == 5'b11000);
   assign is_jal    = (opcode == 5'b11011);

   // address or compare needs a first pass over the operands
   assign two_stage = is_load | is_store | is_branch;

   assign sign_bit = i_ibus_rdt[31];
   assign new_op   = i_ibus_rdt[6:2];

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         opcode     <= new_op;
         funct3     <= i_ibus_rdt[14:12];
         o_rd_addr  <= i_ibus_rdt[11:7];
         o_rs2_addr <= i_ibus_rdt[24:20];
         sub_bit    <= i_ibus_rdt[30];
         // lui adds its immediate to x0
         o_rs1_addr <= (new_op == 5'b01101) ? 5'd0 : i_ibus_rdt[19:15];
         case (new_op)
            5'b01000: imm <= {{21{sign_bit}}, i_ibus_rdt[30:25], i_ibus_rdt[11:7]};
            5'b11000: imm <= {{20{sign_bit}}, i_ibus_rdt[7], i_ibus_rdt[30:25],
                              i_ibus_rdt[11:8], 1'b0};
            5'b01101: imm <= {i_ibus_rdt[31:12], 12'd0};
            5'b11011: imm <= {{12{sign_bit}}, i_ibus_rdt[19:12], i_ibus_rdt[20],
                              i_ibus_rdt[30:21], 1'b0};
            default:  imm <= {{21{sign_bit}}, i_ibus_rdt[30:20]};
         endcase
      end else if (o_cnt_en) begin
         // rotate so the immediate is intact again after each pass
         imm <= {imm[0], imm[31:1]};
      end
   end

   assign o_imm_bit = imm[0];

   assign o_cnt_en  = (state == bsc_pkg::INIT) | (state == bsc_pkg::RUN);
   assign o_init    = (state == bsc_pkg::INIT);
   assign o_run     = (state == bsc_pkg::RUN);
   assign o_rf_read = (state == bsc_pkg::FETCH_WAIT);

   assign o_dbus_we    = is_store;
   assign o_rd_sel_mem = is_load;
   assign o_op_b_imm   = ~(is_op | is_branch);
   assign o_alu_sub    = is_op & sub_bit;
   assign o_jump_sel   = is_jal | taken_r;
   assign o_pc_en      = o_retire;
   assign o_rf_we      = o_retire & (o_rd_addr != 5'd0) &
                         (is_op | is_opimm | is_lui | is_load | is_jal);

   // 00 arithmetic, 01 xor, 10 or, 11 and
   always_comb begin
      o_alu_bool_op = 2'b00;
      if (is_op | is_opimm) begin
         case (funct3)
            3'b100:  o_alu_bool_op = 2'b01;
            3'b110:  o_alu_bool_op = 2'b10;
            3'b111:  o_alu_bool_op = 2'b11;
            default: o_alu_bool_op = 2'b00;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      o_retire <= 1'b0;
      o_cnt    <= o_cnt + {4'd0, o_cnt_en};
      if (o_retire)
         o_ibus_req <= 1'b1;
      if (i_ibus_ack)
         o_ibus_req <= 1'b0;
      if (i_dbus_ack)
         o_dbus_req <= 1'b0;
      case (state)
         bsc_pkg::IDLE: begin
            if (i_ibus_ack)
               state <= bsc_pkg::FETCH_WAIT;
            else if (i_dbus_ack)
               state <= bsc_pkg::RUN;
         end
         bsc_pkg::FETCH_WAIT: begin
            state <= two_stage ? bsc_pkg::INIT : bsc_pkg::RUN;
         end
         bsc_pkg::INIT: begin
            if (o_cnt == 5'd31) begin
               if (is_branch) begin
                  state   <= bsc_pkg::RUN;
                  // beq takes on equal, bne on not equal
                  taken_r <= i_cmp_eq ^ funct3[0];
               end else begin
                  state      <= bsc_pkg::IDLE;
                  o_dbus_req <= 1'b1;
               end
            end
         end
         bsc_pkg::RUN: begin
            if (o_cnt == 5'd31) begin
               state    <= bsc_pkg::IDLE;
               o_retire <= 1'b1;
            end
         end
         default: state <= bsc_pkg::IDLE;
      endcase
      if (o_retire)
         taken_r <= 1'b0;
      if (i_rst) begin
         state      <= bsc_pkg::IDLE;
         o_cnt      <= 5'd0;
         o_ibus_req <= 1'b1;
         o_dbus_req <= 1'b0;
         o_retire   <= 1'b0;
         taken_r    <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* design/bsc_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bsc_cfg.svh"

module bsc_memory (
   input  wire                      clk,
   input  wire                      i_rst,
   input  wire                      i_en,
   input  wire                      i_we,
   input  wire bsc_pkg::mem_addr_t  i_addr,
   input  wire bsc_pkg::word_t      i_wdata,
   output bsc_pkg::word_t           o_rdata,
   output logic                     o_ack
);

   bsc_pkg::word_t mem [0:`BSC_MEM_WORDS-1];

   always_ff @(posedge clk) begin
      if (i_en) begin
         if (i_we)
            mem[i_addr] <= i_wdata;
         else
            o_rdata <= mem[i_addr];
      end
      o_ack <= i_en & ~i_rst;
   end

endmodule

`default_nettype wire

/* design/bsc_pkg.sv */
`default_nettype none

package bsc_pkg;

   // data or instruction word
   typedef logic [31:0] word_t;

   // register index
   typedef logic [4:0] reg_addr_t;

   // word address into the shared memory
   typedef logic [7:0] mem_addr_t;

   // instruction function field
   typedef logic [2:0] funct3_t;

   // serial bit index within a word
   typedef logic [4:0] bit_cnt_t;

   // decoder sequencing states
   typedef enum logic [1:0] {
      IDLE       = 2'd0,
      INIT       = 2'd1,
      RUN        = 2'd2,
      FETCH_WAIT = 2'd3
   } decode_state_t;

endpackage

`default_nettype wire

/* design/bsc_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module bsc_regfile (
   input  wire                      clk,
   input  wire                      i_rd_en,
   input  wire bsc_pkg::reg_addr_t  i_rs1_addr,
   input  wire bsc_pkg::reg_addr_t  i_rs2_addr,
   input  wire                      i_cnt_en,
   input  wire                      i_we,
   input  wire bsc_pkg::reg_addr_t  i_rd_addr,
   input  wire                      i_rd_bit,
   output logic                     o_rs1_bit,
   output logic                     o_rs2_bit,
   output bsc_pkg::word_t           o_rs2_word,
   output bsc_pkg::word_t           o_rd_word
);

   bsc_pkg::word_t regs [0:31];
   bsc_pkg::word_t rs1_sh;

   assign o_rs1_bit = rs1_sh[0];
   assign o_rs2_bit = o_rs2_word[0];

   always_ff @(posedge clk) begin
      if (i_rd_en) begin
         rs1_sh     <= (i_rs1_addr == 5'd0) ? 32'd0 : regs[i_rs1_addr];
         o_rs2_word <= (i_rs2_addr == 5'd0) ? 32'd0 : regs[i_rs2_addr];
      end else if (i_cnt_en) begin
         // operands rotate back to their value after a full pass
         rs1_sh     <= {rs1_sh[0], rs1_sh[31:1]};
         o_rs2_word <= {o_rs2_word[0], o_rs2_word[31:1]};
      end
      if (i_cnt_en)
         o_rd_word <= {i_rd_bit, o_rd_word[31:1]};
      if (i_we && i_rd_addr != 5'd0)
         regs[i_rd_addr] <= o_rd_word;
   end

endmodule

`default_nettype wire

/* design/bsc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bsc_top (
   input  wire                      clk,
   input  wire                      i_rst,
   input  wire                      i_load_en,
   input  wire bsc_pkg::mem_addr_t  i_load_addr,
   input  wire bsc_pkg::word_t      i_load_data,
   output logic                     o_retire,
   output bsc_pkg::word_t           o_retire_pc,
   output logic                     o_rd_we,
   output bsc_pkg::reg_addr_t       o_rd_addr,
   output bsc_pkg::word_t           o_rd_data
);

   logic ibus_req, ibus_ack, dbus_req, dbus_we, dbus_ack;
   logic cnt_en, init, run, rf_read, imm_bit, alu_sub, op_b_imm;
   logic rd_sel_mem, pc_en, jump_sel, cmp_eq, rs1_bit, rs2_bit, rd_bit;
   logic [1:0] alu_bool_op;
   logic mem_en, mem_we, mem_ack;
   bsc_pkg::bit_cnt_t  cnt;
   bsc_pkg::reg_addr_t rs1_addr, rs2_addr;
   bsc_pkg::mem_addr_t dbus_addr, mem_addr;
   bsc_pkg::word_t     mem_rdata, mem_wdata, rs2_word;

   bsc_decode decode_i (
      .clk(clk), .i_rst(i_rst), .o_ibus_req(ibus_req), .i_ibus_ack(ibus_ack),
      .i_ibus_rdt(mem_rdata), .o_dbus_req(dbus_req), .o_dbus_we(dbus_we),
      .i_dbus_ack(dbus_ack), .o_cnt(cnt), .o_cnt_en(cnt_en), .o_init(init), .o_run(run),
      .o_rf_read(rf_read), .o_rf_we(o_rd_we), .o_rs1_addr(rs1_addr),
      .o_rs2_addr(rs2_addr), .o_rd_addr(o_rd_addr), .o_imm_bit(imm_bit),
      .o_alu_sub(alu_sub), .o_alu_bool_op(alu_bool_op), .o_op_b_imm(op_b_imm),
      .o_rd_sel_mem(rd_sel_mem), .o_pc_en(pc_en), .o_jump_sel(jump_sel),
      .i_cmp_eq(cmp_eq), .o_retire(o_retire));

   bsc_datapath datapath_i (
      .clk(clk), .i_rst(i_rst), .i_cnt(cnt), .i_cnt_en(cnt_en), .i_init(init),
      .i_run(run), .i_rs1_bit(rs1_bit), .i_rs2_bit(rs2_bit), .i_imm_bit(imm_bit),
      .i_alu_sub(alu_sub), .i_alu_bool_op(alu_bool_op), .i_op_b_imm(op_b_imm),
      .i_rd_sel_mem(rd_sel_mem), .i_pc_en(pc_en), .i_jump_sel(jump_sel),
      .i_dbus_rdt(mem_rdata), .o_rd_bit(rd_bit), .o_cmp_eq(cmp_eq),
      .o_pc(o_retire_pc), .o_mem_addr(dbus_addr));

   bsc_regfile regfile_i (
      .clk(clk), .i_rd_en(rf_read), .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
      .i_cnt_en(cnt_en), .i_we(o_rd_we), .i_rd_addr(o_rd_addr), .i_rd_bit(rd_bit),
      .o_rs1_bit(rs1_bit), .o_rs2_bit(rs2_bit), .o_rs2_word(rs2_word),
      .o_rd_word(o_rd_data));

   bsc_bus_arbiter arbiter_i (
      .clk(clk), .i_rst(i_rst), .i_load_en(i_load_en), .i_load_addr(i_load_addr),
      .i_load_data(i_load_data), .i_dbus_req(dbus_req), .i_dbus_we(dbus_we),
      .i_dbus_addr(dbus_addr), .i_dbus_wdata(rs2_word), .i_ibus_req(ibus_req),
      .i_ibus_addr(o_retire_pc[9:2]), .o_mem_en(mem_en), .o_mem_we(mem_we),
      .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata), .i_mem_ack(mem_ack),
      .o_dbus_ack(dbus_ack), .o_ibus_ack(ibus_ack));

   bsc_memory memory_i (
      .clk(clk), .i_rst(i_rst), .i_en(mem_en), .i_we(mem_we), .i_addr(mem_addr),
      .i_wdata(mem_wdata), .o_rdata(mem_rdata), .o_ack(mem_ack));

endmodule

`default_nettype wire

/* include/bsc_cfg.svh */
`ifndef BSC_CFG_SVH
`define BSC_CFG_SVH

// first fetch address after reset
`define BSC_RESET_PC 32'h0000_0000

// depth of the shared program/data memory in 32-bit words
`define BSC_MEM_WORDS 256

// byte address where the data region starts
`define BSC_DATA_BASE 32'h0000_0200

`endif

/* project.f */
+incdir+include
design/bsc_pkg.sv
design/bsc_decode.sv
design/bsc_datapath.sv
design/bsc_regfile.sv
design/bsc_bus_arbiter.sv
design/bsc_memory.sv
design/bsc_top.sv
testbench/bsc_assertions.sv
testbench/bsc_tb.sv

/* testbench/bsc_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module bsc_assertions (
   input wire clk,
   input wire i_rst,
   input wire i_load_en,
   input wire i_mem_en,
   input wire i_mem_ack,
   input wire i_dbus_req,
   input wire i_ibus_req,
   input wire i_dbus_ack,
   input wire i_ibus_ack,
   input wire bsc_pkg::decode_state_t i_state,
   input wire i_retire
);

   int onehot_errs = 0;
   int ack_errs = 0;
   int load_errs = 0;
   int run_errs = 0;
   int retire_errs = 0;
   int fail_count;

   assign fail_count = onehot_errs + ack_errs + load_errs + run_errs + retire_errs;

   // one owner per memory access
   grant_onehot: assert property (@(posedge clk) disable iff (i_rst)
      $onehot0({i_dbus_ack, i_ibus_ack}))
      else begin
         $error("data and fetch acks in the same cycle");
         onehot_errs = onehot_errs + 1;
      end

   ack_after_grant: assert property (@(posedge clk) disable iff (i_rst)
      i_mem_ack |-> $past(i_mem_en))
      else begin
         $error("memory ack without an access in the previous cycle");
         ack_errs = ack_errs + 1;
      end

   // a loader write owns the port, so no core ack can follow it
   load_owns_port: assert property (@(posedge clk) disable iff (i_rst)
      i_load_en |=> !(i_dbus_ack || i_ibus_ack))
      else begin
         $error("core ack after a loader write");
         load_errs = load_errs + 1;
      end

   run_no_request: assert property (@(posedge clk) disable iff (i_rst)
      (i_state == bsc_pkg::RUN) |-> !(i_ibus_req || i_dbus_req))
      else begin
         $error("decoder in RUN with a bus request pending");
         run_errs = run_errs + 1;
      end

   retire_pulse: assert property (@(posedge clk) disable iff (i_rst)
      i_retire |=> !i_retire)
      else begin
         $error("retire held for more than one cycle");
         retire_errs = retire_errs + 1;
      end

endmodule

`default_nettype wire

/* testbench/bsc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bsc_cfg.svh"

module bsc_tb;

   localparam int PROG_WORDS = 64;
   localparam int DATA_WORDS = 16;
   localparam int DATA_WORD0 = `BSC_DATA_BASE / 4;
   localparam int NUM_RETIRES = 200;
   localparam int RESET_CYCLES = 16;
   localparam int CYCLES_PER_RETIRE = 80;
   localparam int LIMIT = NUM_RETIRES * CYCLES_PER_RETIRE + RESET_CYCLES
                          + PROG_WORDS + DATA_WORDS;

   logic               clk;
   logic               rst;
   logic               load_en;
   bsc_pkg::mem_addr_t load_addr;
   bsc_pkg::word_t     load_data;
   logic               retire;
   bsc_pkg::word_t     retire_pc;
   logic               rd_we;
   bsc_pkg::reg_addr_t rd_addr;
   bsc_pkg::word_t     rd_data;

   // model state
   bsc_pkg::word_t image [0:`BSC_MEM_WORDS-1];
   bsc_pkg::word_t regs [0:31];
   bsc_pkg::word_t pc;

   int    cur_test;
   int    retires = 0;
   int    cycles = 0;
   int    total_checks;
   int    total_errors;
   int    checks [1:5];
   int    errors [1:5];
   string names [1:5];

   bsc_top dut_i (
      .clk(clk), .i_rst(rst), .i_load_en(load_en), .i_load_addr(load_addr),
      .i_load_data(load_data), .o_retire(retire), .o_retire_pc(retire_pc),
      .o_rd_we(rd_we), .o_rd_addr(rd_addr), .o_rd_data(rd_data));

   bind bsc_top bsc_assertions assertions_i (
      .clk(clk), .i_rst(i_rst), .i_load_en(i_load_en), .i_mem_en(mem_en),
      .i_mem_ack(mem_ack), .i_dbus_req(dbus_req), .i_ibus_req(ibus_req),
      .i_dbus_ack(dbus_ack), .i_ibus_ack(ibus_ack), .i_state(decode_i.state),
      .i_retire(o_retire));

   initial clk = 1'b0;
   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > LIMIT) begin
         $display("timeout: %0d of %0d retires seen after %0d cycles",
                  retires, NUM_RETIRES, cycles);
         $display("TB FAILED");
         $finish;
      end
   end

   task automatic check_word(input string name, input bsc_pkg::word_t got,
                             input bsc_pkg::word_t exp);
      checks[cur_test] = checks[cur_test] + 1;
      if (got !== exp) begin
         errors[cur_test] = errors[cur_test] + 1;
         $display("CHECK FAILED t=%0t %s: got %08h, expected %08h", $time, name, got, exp);
      end
   endtask

   task automatic check_reg(input string name, input bsc_pkg::reg_addr_t got,
                            input bsc_pkg::reg_addr_t exp);
      checks[cur_test] = checks[cur_test] + 1;
      if (got !== exp) begin
         errors[cur_test] = errors[cur_test] + 1;
         $display("CHECK FAILED t=%0t %s: got x%0d, expected x%0d", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks[cur_test] = checks[cur_test] + 1;
      if (got !== exp) begin
         errors[cur_test] = errors[cur_test] + 1;
         $display("CHECK FAILED t=%0t %s: got %b, expected %b", $time, name, got, exp);
      end
   endtask

   // fill word that differs for every word address
   function automatic bsc_pkg::word_t fill_word(input bsc_pkg::mem_addr_t a);
      return {~a, a, a ^ 8'h3c, a + 8'h91};
   endfunction

   function automatic bsc_pkg::word_t itype_word(input logic [11:0] imm,
         input bsc_pkg::reg_addr_t rs1, input bsc_pkg::funct3_t f3,
         input bsc_pkg::reg_addr_t rd, input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic bsc_pkg::word_t rtype_word(input logic [6:0] f7,
         input bsc_pkg::reg_addr_t rs2, input bsc_pkg::reg_addr_t rs1,
         input bsc_pkg::reg_addr_t rd);
      return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
   endfunction

   function automatic bsc_pkg::word_t stype_word(input logic [11:0] imm,
         input bsc_pkg::reg_addr_t rs2, input bsc_pkg::reg_addr_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic bsc_pkg::word_t btype_word(input logic [12:0] off,
         input bsc_pkg::reg_addr_t rs2, input bsc_pkg::reg_addr_t rs1,
         input bsc_pkg::funct3_t f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic bsc_pkg::word_t jtype_word(input logic [20:0] off,
         input bsc_pkg::reg_addr_t rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   task automatic make_program();
      bsc_pkg::word_t     r;
      bsc_pkg::reg_addr_t rd;
      bsc_pkg::reg_addr_t rs1;
      bsc_pkg::reg_addr_t rs2;
      int kind;
      int tgt;
      int off;
      int last_off;
      last_off = 0;
      for (int a = 0; a < `BSC_MEM_WORDS; a++)
         image[a] = fill_word(8'(a));
      // x1..x7 get known values first
      for (int k = 1; k < 8; k++) begin
         r = $urandom;
         image[k - 1] = itype_word(r[11:0], 5'd0, 3'b000, 5'(k), 7'b0010011);
      end
      for (int i = 7; i < PROG_WORDS - 1; i++) begin
         r    = $urandom;
         rd   = 5'($urandom % 8);
         rs1  = 5'($urandom % 8);
         rs2  = 5'($urandom % 8);
         kind = int'($urandom % 11);
         // forward target inside the program
         tgt  = i + 1 + int'($urandom % (PROG_WORDS - 1 - i));
         off  = ($urandom % 2 == 0) ? last_off : int'($urandom % DATA_WORDS);
         case (kind)
            0: image[i] = itype_word(r[11:0], rs1, 3'b000, rd, 7'b0010011);
            1: image[i] = itype_word(r[11:0], rs1, 3'b100, rd, 7'b0010011);
            2: image[i] = itype_word(r[11:0], rs1, 3'b110, rd, 7'b0010011);
            3: image[i] = itype_word(r[11:0], rs1, 3'b111, rd, 7'b0010011);
            4: image[i] = rtype_word(7'b0000000, rs2, rs1, rd);
            5: image[i] = rtype_word(7'b0100000, rs2, rs1, rd);
            6: image[i] = {r[31:12], rd, 7'b0110111};
            7: image[i] = itype_word(12'(`BSC_DATA_BASE + 4 * off), 5'd0, 3'b010, rd,
                                     7'b0000011);
            8: begin
               image[i] = stype_word(12'(`BSC_DATA_BASE + 4 * off), rs2, 5'd0);
               last_off = off;
            end
            9: image[i] = btype_word(13'((tgt - i) * 4), rs2, rs1, {2'b00, r[0]});
            default: image[i] = jtype_word(21'((tgt - i) * 4), rd);
         endcase
      end
      // program ends in a jump to itself
      image[PROG_WORDS - 1] = jtype_word(21'd0, 5'($urandom % 8));
   endtask

   // steps the model by one instruction and compares the retire outputs
   task automatic compare_retire();
      bsc_pkg::word_t     ins;
      bsc_pkg::word_t     a;
      bsc_pkg::word_t     b;
      bsc_pkg::word_t     imm_i;
      bsc_pkg::word_t     imm_s;
      bsc_pkg::word_t     imm_b;
      bsc_pkg::word_t     imm_j;
      bsc_pkg::word_t     val;
      bsc_pkg::word_t     next_pc;
      bsc_pkg::reg_addr_t rd;
      bsc_pkg::funct3_t   f3;
      logic               we;
      int                 cat;
      ins     = image[pc[9:2]];
      f3      = ins[14:12];
      rd      = ins[11:7];
      a       = regs[ins[19:15]];
      b       = regs[ins[24:20]];
      imm_i   = {{20{ins[31]}}, ins[31:20]};
      imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      next_pc = pc + 32'd4;
      we      = 1'b1;
      val     = 32'd0;
      cat     = 2;
      case (ins[6:0])
         7'b0010011: begin
            case (f3)
               3'b100:  val = a ^ imm_i;
               3'b110:  val = a | imm_i;
               3'b111:  val = a & imm_i;
               default: val = a + imm_i;
            endcase
         end
         7'b0110011: val = ins[30] ? a - b : a + b;
         7'b0110111: val = {ins[31:12], 12'd0};
         7'b0000011: begin
            cat = 3;
            val = image[8'((a + imm_i) >> 2)];
         end
         7'b0100011: begin
            cat = 3;
            we  = 1'b0;
            image[8'((a + imm_s) >> 2)] = b;
         end
         7'b1100011: begin
            cat = 4;
            we  = 1'b0;
            // beq takes on equal, bne on not equal
            if ((a == b) != f3[0])
               next_pc = pc + imm_b;
         end
         7'b1101111: begin
            cat     = 4;
            val     = pc + 32'd4;
            next_pc = pc + imm_j;
         end
         default: we = 1'b0;
      endcase
      if (retires == 0) begin
         cur_test = 1;
         check_word("o_retire_pc", retire_pc, `BSC_RESET_PC);
      end
      cur_test = 5;
      check_word("o_retire_pc", retire_pc, pc);
      cur_test = cat;
      if (we && rd != 5'd0) begin
         check_flag("o_rd_we", rd_we, 1'b1);
         check_reg("o_rd_addr", rd_addr, rd);
         check_word("o_rd_data", rd_data, val);
         regs[rd] = val;
      end else begin
         check_flag("o_rd_we", rd_we, 1'b0);
      end
      pc = next_pc;
   endtask

   task automatic report_test(input int t);
      $display("test %0d %s: %0d checks, %0d errors, %s", t, names[t], checks[t],
               errors[t], (errors[t] == 0) ? "ok" : "failing");
   endtask

   initial begin
      rst       = 1'b1;
      load_en   = 1'b0;
      load_addr = 8'd0;
      load_data = 32'd0;
      names[1]  = "reset and first retire";
      names[2]  = "alu and lui writes";
      names[3]  = "load and store";
      names[4]  = "branch and jal";
      names[5]  = "retired pc sequence";
      for (int t = 1; t <= 5; t++) begin
         checks[t] = 0;
         errors[t] = 0;
      end
      for (int k = 0; k < 32; k++)
         regs[k] = 32'd0;
      void'($urandom(32'h1f56c510));
      make_program();
      cur_test = 1;

      // loader owns the port every cycle, so the first fetch waits for it
      for (int n = 0; n < PROG_WORDS + DATA_WORDS; n++) begin
         @(negedge clk);
         if (n == RESET_CYCLES - 1)
            rst = 1'b0;
         if (n > 0) begin
            check_flag("o_retire", retire, 1'b0);
            check_flag("o_rd_we", rd_we, 1'b0);
         end
         load_en   = 1'b1;
         load_addr = (n < PROG_WORDS) ? 8'(n) : 8'(DATA_WORD0 + n - PROG_WORDS);
         load_data = image[load_addr];
      end
      @(negedge clk);
      load_en = 1'b0;

      pc = `BSC_RESET_PC;
      while (retires < NUM_RETIRES) begin
         @(negedge clk);
         if (retire) begin
            compare_retire();
            retires = retires + 1;
            if (retires == 1)
               report_test(1);
         end else if (retires == 0) begin
            cur_test = 1;
            check_flag("o_rd_we", rd_we, 1'b0);
         end
      end

      total_checks = 0;
      total_errors = 0;
      for (int t = 2; t <= 5; t++)
         report_test(t);
      for (int t = 1; t <= 5; t++) begin
         total_checks = total_checks + checks[t];
         total_errors = total_errors + errors[t];
      end
      $display("summary: %0d retires, %0d checks, %0d errors, %0d assertion failures",
               retires, total_checks, total_errors, dut_i.assertions_i.fail_count);
      if (total_errors == 0 && dut_i.assertions_i.fail_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
